//--- common/array_geom_pkg.sv
package array_geom_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Array dimensions
    ////////////////////////////////////////////////////////////////////////////

    // Operand matrices are MATRIX_SIZE x MATRIX_SIZE
    localparam int MATRIX_SIZE = 4;

    // Grid is wide enough to hold every diagonal of the skewed product
    localparam int ARRAY_SIZE = 2 * MATRIX_SIZE - 1;

    // Vector lanes carried by each left operand and partial sum
    localparam int LANES = 2;

    // Operand and accumulator width
    // Products and sums wrap at this width
    localparam int DATA_WIDTH = 16;

    ////////////////////////////////////////////////////////////////////////////
    // Result taps
    ////////////////////////////////////////////////////////////////////////////

    // Chains ending on the bottom row, columns MATRIX_SIZE-1 up to the corner
    localparam int NUM_BOTTOM_TAPS = MATRIX_SIZE;

    // Chains ending on the right column, rows MATRIX_SIZE-1 up to ARRAY_SIZE-2
    // The corner cell belongs to the bottom set
    localparam int NUM_RIGHT_TAPS = MATRIX_SIZE - 1;

    ////////////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////////////

    // One operand or sum word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Lane vector
    // Lane 0 sits in the low word
    // Used for left operands, partial sums and results
    typedef data_t [LANES-1:0] lane_vec_t;

endpackage

//--- common/cell_map_pkg.sv
package cell_map_pkg;

    import array_geom_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Cell classification
    ////////////////////////////////////////////////////////////////////////////

    // First row on the right column and first column on the bottom row
    // that end a diagonal chain
    localparam int TAP_FIRST = MATRIX_SIZE - 1;

    // MAC cells form a band around the main diagonal
    // Everything outside the band only forwards operands
    function automatic bit is_mac_cell(input int row, input int col);
        int diff;
        diff = row - col;
        // Band is MATRIX_SIZE-1 cells wide on each side of the diagonal
        return (diff < MATRIX_SIZE) && (diff > -MATRIX_SIZE);
    endfunction

    // Chain index of a cell is col - row
    // Negative chains end on the bottom row at column ARRAY_SIZE-1+chain
    // Positive chains end on the right column at row ARRAY_SIZE-1-chain
    // Chain 0 ends in the corner and is counted with the bottom taps

endpackage

//--- verilog/edge_operand_regs.sv
module edge_operand_regs (
    input  logic                      clk,
    input  logic                      arst_n,
    // Row operands entering from the left edge
    input  array_geom_pkg::lane_vec_t left_in   [array_geom_pkg::ARRAY_SIZE],
    // Column operands entering from the top edge
    input  array_geom_pkg::data_t     top_in    [array_geom_pkg::ARRAY_SIZE],
    // Registered copies seen by column 0 and row 0 of the grid
    output array_geom_pkg::lane_vec_t edge_left [array_geom_pkg::ARRAY_SIZE],
    output array_geom_pkg::data_t     edge_top  [array_geom_pkg::ARRAY_SIZE]
);

    import array_geom_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Input register stage
    ////////////////////////////////////////////////////////////////////////////

    // One cycle from the pins to the grid boundary
    // Keeps external input timing apart from the first MAC multiplier
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < ARRAY_SIZE; i++) begin
                edge_left[i] <= '0;
                edge_top[i]  <= '0;
            end
        end else begin
            // Whole edge moves in lockstep
            for (int i = 0; i < ARRAY_SIZE; i++) begin
                edge_left[i] <= left_in[i];
                edge_top[i]  <= top_in[i];
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    // An X entering here spreads along a whole row or column
    // and then into every diagonal sum it crosses
    for (genvar i = 0; i < ARRAY_SIZE; i++) begin : g_in_check
        a_left_known : assert property (
            @(posedge clk) disable iff (!arst_n)
            !$isunknown(left_in[i])
        );
        a_top_known : assert property (
            @(posedge clk) disable iff (!arst_n)
            !$isunknown(top_in[i])
        );
    end

endmodule

//--- systolic_array/mac_cell.sv
module mac_cell (
    input  logic                      clk,
    input  logic                      arst_n,
    // Left operand, one word per lane
    input  array_geom_pkg::lane_vec_t a_in,
    // Top operand, shared by both lanes
    input  array_geom_pkg::data_t     b_in,
    // Partial sum from the upper-left neighbour
    input  array_geom_pkg::lane_vec_t sum_in,
    output array_geom_pkg::lane_vec_t a_out,
    output array_geom_pkg::data_t     b_out,
    output array_geom_pkg::lane_vec_t sum_out
);

    import array_geom_pkg::*;

    // Per-lane product, truncated to the word width
    lane_vec_t prod;

    always_comb begin
        for (int l = 0; l < LANES; l++) begin
            // Same top word multiplies every lane
            prod[l] = data_t'(a_in[l] * b_in);
        end
    end

    // Operands move on one cell per clock
    // Sum moves one diagonal step per clock
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_out   <= '0;
            b_out   <= '0;
            sum_out <= '0;
        end else begin
            a_out <= a_in;
            b_out <= b_in;
            for (int l = 0; l < LANES; l++) begin
                // Wraps at DATA_WIDTH like the product
                sum_out[l] <= sum_in[l] + prod[l];
            end
        end
    end

    // Sum depends on the whole upstream diagonal and both operand paths
    a_sum_known : assert property (
        @(posedge clk) disable iff (!arst_n)
        !$isunknown(sum_out)
    );

endmodule

//--- systolic_array/systolic_grid.sv
module systolic_grid (
    input  logic                      clk,
    input  logic                      arst_n,
    // Registered operands at the left and top boundary
    input  array_geom_pkg::lane_vec_t edge_left    [array_geom_pkg::ARRAY_SIZE],
    input  array_geom_pkg::data_t     edge_top     [array_geom_pkg::ARRAY_SIZE],
    // Chain ends on the bottom row, index i is column TAP_FIRST+i
    output array_geom_pkg::lane_vec_t chain_bottom [array_geom_pkg::NUM_BOTTOM_TAPS],
    // Chain ends on the right column, index i is row TAP_FIRST+i
    output array_geom_pkg::lane_vec_t chain_right  [array_geom_pkg::NUM_RIGHT_TAPS]
);

    import array_geom_pkg::*;
    import cell_map_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Grid wiring
    ////////////////////////////////////////////////////////////////////////////

    // Registered outputs of every cell, indexed [row][col]
    // a_q runs rightward, b_q runs downward
    lane_vec_t a_q   [ARRAY_SIZE][ARRAY_SIZE];
    data_t     b_q   [ARRAY_SIZE][ARRAY_SIZE];
    // Partial sums run down and right along the diagonals
    lane_vec_t sum_q [ARRAY_SIZE][ARRAY_SIZE];

    for (genvar r = 0; r < ARRAY_SIZE; r++) begin : g_row
        for (genvar c = 0; c < ARRAY_SIZE; c++) begin : g_col

            // Operands arriving at this cell
            lane_vec_t a_src;
            data_t     b_src;

            // Left operand comes from the edge or the left neighbour
            if (c == 0) begin : g_a_edge
                assign a_src = edge_left[r];
            end else begin : g_a_inner
                assign a_src = a_q[r][c-1];
            end

            // Top word comes from the edge or the neighbour above
            if (r == 0) begin : g_b_edge
                assign b_src = edge_top[c];
            end else begin : g_b_inner
                assign b_src = b_q[r-1][c];
            end

            if (is_mac_cell(r, c)) begin : g_mac
                lane_vec_t sum_src;

                // Diagonals start at zero on row 0 and column 0
                if (r == 0 || c == 0) begin : g_sum_zero
                    assign sum_src = '0;
                end else begin : g_sum_diag
                    // Upper-left neighbour is on the same diagonal
                    // so it is always inside the band as well
                    assign sum_src = sum_q[r-1][c-1];
                end

                mac_cell u_mac (
                    .clk     (clk),
                    .arst_n  (arst_n),
                    .a_in    (a_src),
                    .b_in    (b_src),
                    .sum_in  (sum_src),
                    .a_out   (a_q[r][c]),
                    .b_out   (b_q[r][c]),
                    .sum_out (sum_q[r][c])
                );
            end else begin : g_pass
                // Corner triangles outside the band
                // Operands need the same one cycle step as in a MAC cell
                lane_vec_t a_dly;
                data_t     b_dly;

                always_ff @(posedge clk or negedge arst_n) begin
                    if (!arst_n) begin
                        a_dly <= '0;
                        b_dly <= '0;
                    end else begin
                        a_dly <= a_src;
                        b_dly <= b_src;
                    end
                end

                assign a_q[r][c] = a_dly;
                assign b_q[r][c] = b_dly;
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Chain end taps
    ////////////////////////////////////////////////////////////////////////////

    // Bottom row, columns TAP_FIRST up to the corner
    for (genvar i = 0; i < NUM_BOTTOM_TAPS; i++) begin : g_tap_bottom
        assign chain_bottom[i] = sum_q[ARRAY_SIZE-1][TAP_FIRST+i];
    end

    // Right column, rows TAP_FIRST up to just above the corner
    for (genvar i = 0; i < NUM_RIGHT_TAPS; i++) begin : g_tap_right
        assign chain_right[i] = sum_q[TAP_FIRST+i][ARRAY_SIZE-1];
    end

endmodule

//--- verilog/result_tap_regs.sv
module result_tap_regs (
    input  logic                      clk,
    input  logic                      arst_n,
    // Diagonal chain ends from the grid
    input  array_geom_pkg::lane_vec_t chain_bottom [array_geom_pkg::NUM_BOTTOM_TAPS],
    input  array_geom_pkg::lane_vec_t chain_right  [array_geom_pkg::NUM_RIGHT_TAPS],
    // Registered results, same ordering as the chain inputs
    output array_geom_pkg::lane_vec_t bottom_out   [array_geom_pkg::NUM_BOTTOM_TAPS],
    output array_geom_pkg::lane_vec_t right_out    [array_geom_pkg::NUM_RIGHT_TAPS]
);

    import array_geom_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Output register stage
    ////////////////////////////////////////////////////////////////////////////

    // Last diagonal adder ends at a flop, not at a pin
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < NUM_BOTTOM_TAPS; i++) begin
                bottom_out[i] <= '0;
            end
            for (int i = 0; i < NUM_RIGHT_TAPS; i++) begin
                right_out[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_BOTTOM_TAPS; i++) begin
                bottom_out[i] <= chain_bottom[i];
            end
            for (int i = 0; i < NUM_RIGHT_TAPS; i++) begin
                right_out[i] <= chain_right[i];
            end
        end
    end

    // Whatever the grid holds, results read zero one cycle after reset
    for (genvar i = 0; i < NUM_BOTTOM_TAPS; i++) begin : g_chk_bottom
        a_bottom_cleared : assert property (
            @(posedge clk) !arst_n |=> (bottom_out[i] == '0)
        );
    end
    for (genvar i = 0; i < NUM_RIGHT_TAPS; i++) begin : g_chk_right
        a_right_cleared : assert property (
            @(posedge clk) !arst_n |=> (right_out[i] == '0)
        );
    end

endmodule

//--- verilog/systolic_top.sv
module systolic_top (
    input  logic                      clk,
    input  logic                      arst_n,
    // Skewed row operands, two lanes per row
    input  array_geom_pkg::lane_vec_t left_in    [array_geom_pkg::ARRAY_SIZE],
    // Skewed column operands, one word per column
    input  array_geom_pkg::data_t     top_in     [array_geom_pkg::ARRAY_SIZE],
    // Results in natural order, index i is column or row TAP_FIRST+i
    output array_geom_pkg::lane_vec_t bottom_out [array_geom_pkg::NUM_BOTTOM_TAPS],
    output array_geom_pkg::lane_vec_t right_out  [array_geom_pkg::NUM_RIGHT_TAPS]
);

    import array_geom_pkg::*;

    // Boundary operands after the input stage
    lane_vec_t edge_left    [ARRAY_SIZE];
    data_t     edge_top     [ARRAY_SIZE];

    // Raw chain ends ahead of the output stage
    lane_vec_t chain_bottom [NUM_BOTTOM_TAPS];
    lane_vec_t chain_right  [NUM_RIGHT_TAPS];

    ////////////////////////////////////////////////////////////////////////////
    // Input stage, grid, output stage
    ////////////////////////////////////////////////////////////////////////////

    edge_operand_regs u_edge_operand_regs (
        .clk       (clk),
        .arst_n    (arst_n),
        .left_in   (left_in),
        .top_in    (top_in),
        .edge_left (edge_left),
        .edge_top  (edge_top)
    );

    // One register per cell, diagonal sums accumulate inside
    systolic_grid u_systolic_grid (
        .clk          (clk),
        .arst_n       (arst_n),
        .edge_left    (edge_left),
        .edge_top     (edge_top),
        .chain_bottom (chain_bottom),
        .chain_right  (chain_right)
    );

    result_tap_regs u_result_tap_regs (
        .clk          (clk),
        .arst_n       (arst_n),
        .chain_bottom (chain_bottom),
        .chain_right  (chain_right),
        .bottom_out   (bottom_out),
        .right_out    (right_out)
    );

endmodule

//--- tb/tb_systolic_top.sv
module tb_systolic_top;

    timeunit 1ns;
    timeprecision 1ps;

    import array_geom_pkg::*;
    import cell_map_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // Run lengths
    ////////////////////////////////////////////////////////////////////////////

    localparam logic [31:0] SEED = 32'hd5d8a234;
    localparam int NUM_TAPS      = NUM_BOTTOM_TAPS + NUM_RIGHT_TAPS;
    localparam int MAX_EDGES     = 512;
    localparam int RESET_CYCLES  = 10;
    localparam int SETTLE_CYCLES = 4;
    // Longest path is a full row, a full chain and both edge stages
    localparam int DRAIN_CYCLES  = 2 * ARRAY_SIZE + 2;
    localparam int IMPULSE_STEPS = DRAIN_CYCLES + 4;
    localparam int MATRIX_STEPS  = 2 * MATRIX_SIZE - 1 + DRAIN_CYCLES;
    localparam int PARTIAL_STEPS = MATRIX_SIZE + 2;
    localparam int MIDRST_CYCLES = 3;
    // One per chain, two lane tests, four pass-through cells
    localparam int NUM_IMPULSES  = NUM_TAPS + 2 + 4;
    localparam int TEST_CYCLES   = RESET_CYCLES + SETTLE_CYCLES
                                 + NUM_IMPULSES * IMPULSE_STEPS
                                 + 3 * MATRIX_STEPS + PARTIAL_STEPS + MIDRST_CYCLES;
    localparam int TIMEOUT_CYCLES = TEST_CYCLES + 4 * ARRAY_SIZE;

    logic      clk;
    logic      arst_n;
    lane_vec_t left_in    [ARRAY_SIZE];
    data_t     top_in     [ARRAY_SIZE];
    lane_vec_t bottom_out [NUM_BOTTOM_TAPS];
    lane_vec_t right_out  [NUM_RIGHT_TAPS];

    // Values for the next edge
    lane_vec_t stage_left [ARRAY_SIZE];
    data_t     stage_top  [ARRAY_SIZE];
    logic      stage_rst;

    // Inputs sampled by the DUT, indexed by edge number
    lane_vec_t hist_left [MAX_EDGES][ARRAY_SIZE];
    data_t     hist_top  [MAX_EDGES][ARRAY_SIZE];
    int        edge_cnt;
    int        last_edge;
    // Latest edge that left the array cleared
    int        last_rst;
    int        errors;

    systolic_top dut_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .left_in    (left_in),
        .top_in     (top_in),
        .bottom_out (bottom_out),
        .right_out  (right_out)
    );

    always #2 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // Reporting and compare tasks
    ////////////////////////////////////////////////////////////////////////////

    task automatic fail_run(input string msg);
        errors++;
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_lane_vec(input string name, input lane_vec_t exp, input lane_vec_t act);
        if (act !== exp) begin
            fail_run($sformatf("Error at %0t: %s expected %h actual %h",
                               $time, name, exp, act));
        end
    endtask

    task automatic check_word(input string name, input data_t exp, input data_t act);
        if (act !== exp) begin
            fail_run($sformatf("Error at %0t: %s expected %h actual %h",
                               $time, name, exp, act));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tap lookup and reference model
    ////////////////////////////////////////////////////////////////////////////

    // Taps 0..3 are the bottom row, the rest the right column
    function automatic lane_vec_t tap_out(input int j);
        if (j < NUM_BOTTOM_TAPS) begin
            return bottom_out[j];
        end
        return right_out[j - NUM_BOTTOM_TAPS];
    endfunction

    function automatic string tap_name(input int j);
        if (j < NUM_BOTTOM_TAPS) begin
            return $sformatf("bottom_out[%0d]", j);
        end
        return $sformatf("right_out[%0d]", j - NUM_BOTTOM_TAPS);
    endfunction

    function automatic int tap_row(input int j);
        return (j < NUM_BOTTOM_TAPS) ? ARRAY_SIZE - 1 : TAP_FIRST + j - NUM_BOTTOM_TAPS;
    endfunction

    function automatic int tap_col(input int j);
        return (j < NUM_BOTTOM_TAPS) ? TAP_FIRST + j : ARRAY_SIZE - 1;
    endfunction

    // Result held after edge e for the chain ending at (re,ce)
    // Cell d steps up the chain multiplies during the cycle after edge k = e-2-d
    // Left word there was sampled at k-c, top word at k-r
    function automatic lane_vec_t model_tap(input int re, input int ce, input int e);
        lane_vec_t   acc;
        int          r;
        int          c;
        int          k;
        int          li;
        int          ti;
        int unsigned prod;
        acc = '0;
        for (int d = 0; d <= re && d <= ce; d++) begin
            r  = re - d;
            c  = ce - d;
            k  = e - 2 - d;
            li = k - c;
            ti = k - r;
            // Anything sampled at or before a reset is gone
            if (is_mac_cell(r, c) && li > last_rst && ti > last_rst) begin
                for (int l = 0; l < LANES; l++) begin
                    prod   = 32'(hist_left[li][r][l]) * 32'(hist_top[ti][c]);
                    acc[l] = data_t'(acc[l] + prod);
                end
            end
        end
        return acc;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Clock step
    ////////////////////////////////////////////////////////////////////////////

    task automatic clear_stage();
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            stage_left[i] = '0;
            stage_top[i]  = '0;
        end
    endtask

    // Records what the DUT samples, drives the staged values,
    // then checks every tap at the falling edge
    task automatic cycle();
        int e;
        @(posedge clk);
        e = edge_cnt;
        if (e >= MAX_EDGES) begin
            fail_run("Input history is full, the tests ran longer than expected");
        end
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            hist_left[e][i] = left_in[i];
            hist_top[e][i]  = top_in[i];
        end
        // Low before or right after this edge leaves all registers at zero
        if (!arst_n || !stage_rst) begin
            last_rst = e;
        end
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            left_in[i] <= stage_left[i];
            top_in[i]  <= stage_top[i];
        end
        arst_n   <= stage_rst;
        edge_cnt = e + 1;
        @(negedge clk);
        last_edge = e;
        for (int j = 0; j < NUM_TAPS; j++) begin
            check_lane_vec(tap_name(j), model_tap(tap_row(j), tap_col(j), e), tap_out(j));
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    // One left pulse on row rs and one top word on column cs, timed to meet at (rs,cs)
    task automatic inject_meet(input int rs, input int cs,
                               input data_t a0, input data_t a1, input data_t b);
        int        dl;
        int        dt;
        int        re;
        int        j;
        int        exp_edge;
        lane_vec_t act;
        dl = (rs > cs) ? rs - cs : 0;
        dt = (cs > rs) ? cs - rs : 0;
        // End of the diagonal through (rs,cs)
        if (cs <= rs) begin
            re = ARRAY_SIZE - 1;
            j  = ARRAY_SIZE - 1 + cs - rs - TAP_FIRST;
        end else begin
            re = ARRAY_SIZE - 1 - (cs - rs);
            j  = NUM_BOTTOM_TAPS + re - TAP_FIRST;
        end
        // Left sample edge, plus cs hops, then one per row down the chain and the output stage
        exp_edge = edge_cnt + 1 + dl + cs + 2 + (re - rs);
        for (int s = 0; s < IMPULSE_STEPS; s++) begin
            clear_stage();
            if (s == dl) begin
                stage_left[rs][0] = a0;
                stage_left[rs][1] = a1;
            end
            if (s == dt) begin
                stage_top[cs] = b;
            end
            cycle();
            if (!is_mac_cell(rs, cs)) begin
                for (int t = 0; t < NUM_TAPS; t++) begin
                    check_lane_vec(tap_name(t), '0, tap_out(t));
                end
            end else begin
                act = tap_out(j);
                if (last_edge == exp_edge - 1) begin
                    check_lane_vec(tap_name(j), '0, act);
                end
                if (last_edge == exp_edge) begin
                    check_word({tap_name(j), " lane 0"}, data_t'(a0 * b), act[0]);
                    check_word({tap_name(j), " lane 1"}, data_t'(a1 * b), act[1]);
                end
            end
        end
    endtask

    // Row i of each A and column i of B enter i cycles late
    task automatic stream_matrix(input int steps);
        data_t a0 [MATRIX_SIZE][MATRIX_SIZE];
        data_t a1 [MATRIX_SIZE][MATRIX_SIZE];
        data_t b  [MATRIX_SIZE][MATRIX_SIZE];
        int    idx;
        for (int i = 0; i < MATRIX_SIZE; i++) begin
            for (int k = 0; k < MATRIX_SIZE; k++) begin
                a0[i][k] = data_t'($urandom());
                a1[i][k] = data_t'($urandom());
                b[i][k]  = data_t'($urandom());
            end
        end
        for (int s = 0; s < steps; s++) begin
            clear_stage();
            for (int i = 0; i < MATRIX_SIZE; i++) begin
                idx = s - i;
                if (idx >= 0 && idx < MATRIX_SIZE) begin
                    stage_left[i][0] = a0[i][idx];
                    stage_left[i][1] = a1[i][idx];
                    stage_top[i]     = b[idx][i];
                end
            end
            cycle();
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic test_reset();
        clear_stage();
        stage_rst = 1'b0;
        repeat (RESET_CYCLES) cycle();
        stage_rst = 1'b1;
        repeat (SETTLE_CYCLES) cycle();
    endtask

    // Meet at the first cell of every chain, lane 1 stays zero
    task automatic test_impulses();
        int m;
        for (int j = 0; j < NUM_TAPS; j++) begin
            m = (tap_row(j) < tap_col(j)) ? tap_row(j) : tap_col(j);
            inject_meet(tap_row(j) - m, tap_col(j) - m,
                        data_t'($urandom()) | 16'h1, '0, data_t'($urandom()) | 16'h1);
        end
    endtask

    task automatic test_lanes();
        inject_meet(2, 4, 16'h1234, 16'hfedc, 16'h0033);
        inject_meet(5, 3, data_t'($urandom()), data_t'($urandom()), data_t'($urandom()));
    endtask

    // Corner cells outside the band, operands only cross there
    task automatic test_pass_through();
        inject_meet(6, 0, 16'h7001, 16'h7002, 16'h0101);
        inject_meet(0, 6, 16'h1111, 16'h2222, 16'h0202);
        inject_meet(5, 1, 16'hbeef, 16'h0f0f, 16'h0303);
        inject_meet(1, 6, 16'hcafe, 16'h00ff, 16'h0404);
    endtask

    task automatic test_matrix();
        repeat (2) stream_matrix(MATRIX_STEPS);
    endtask

    task automatic test_mid_reset();
        stream_matrix(PARTIAL_STEPS);
        clear_stage();
        stage_rst = 1'b0;
        repeat (MIDRST_CYCLES) cycle();
        stage_rst = 1'b1;
        stream_matrix(MATRIX_STEPS);
    endtask

    initial begin : watchdog
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        fail_run($sformatf("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES));
    end

    initial begin : main
        void'($urandom(SEED));
        clk       = 1'b0;
        arst_n    = 1'b0;
        stage_rst = 1'b0;
        for (int i = 0; i < ARRAY_SIZE; i++) begin
            left_in[i] = '0;
            top_in[i]  = '0;
        end
        clear_stage();
        edge_cnt  = 0;
        last_edge = -1;
        last_rst  = -1;
        errors    = 0;
        test_reset();
        test_impulses();
        test_lanes();
        test_pass_through();
        test_matrix();
        test_mid_reset();
        if (errors == 0) begin
            $display("** PASS **");
            $finish;
        end else begin
            $display("** FAIL **");
            $fatal(1, "Errors found");
        end
    end

endmodule

//--- sources.f
common/array_geom_pkg.sv
common/cell_map_pkg.sv
verilog/edge_operand_regs.sv
systolic_array/mac_cell.sv
systolic_array/systolic_grid.sv
verilog/result_tap_regs.sv
verilog/systolic_top.sv
tb/tb_systolic_top.sv

//--- Bender.yml
package:
  name: systolic_array

sources:
  # Packages first, then the design bottom up
  - files:
      - common/array_geom_pkg.sv
      - common/cell_map_pkg.sv
      - verilog/edge_operand_regs.sv
      - systolic_array/mac_cell.sv
      - systolic_array/systolic_grid.sv
      - verilog/result_tap_regs.sv
      - verilog/systolic_top.sv

  # Testbench
  - target: test
    files:
      - tb/tb_systolic_top.sv
